//--- hw/noc_pkg.sv
`default_nettype none

package noc_pkg;

  // Network size and field widths
  localparam int NOC_SIZE  = 4;
  localparam int NODE_ID_W = 2;
  localparam int DATA_W    = 32;

  // Receive queue geometry
  localparam int RX_DEPTH  = 4;
  localparam int RX_PTR_W  = $clog2(RX_DEPTH);
  localparam int RX_CNT_W  = $clog2(RX_DEPTH + 1);

  typedef logic [NODE_ID_W-1:0] node_id_t;

  // Single flit message of 36 bits with the default sizes
  typedef struct packed {
    node_id_t            src;
    node_id_t            dest;
    logic [DATA_W-1:0]   data;
  } flit_t;

endpackage

`default_nettype wire

//--- hw/ni_port_if.sv
`timescale 1ns/1ns
`default_nettype none

interface ni_port_if;

  // Host write toward the tile
  logic                        wr_valid;
  noc_pkg::node_id_t           wr_dest;
  logic [noc_pkg::DATA_W-1:0]  wr_data;
  logic                        wr_ready;

  // Host read from the tile receive queue
  logic                        rd_valid;
  logic [noc_pkg::DATA_W-1:0]  rd_data;
  noc_pkg::node_id_t           rd_src;
  logic                        rd_ready;

  logic                        irq;

  modport mux (
    output wr_valid, wr_dest, wr_data, rd_ready,
    input  wr_ready, rd_valid, rd_data, rd_src, irq
  );

  modport node (
    input  wr_valid, wr_dest, wr_data, rd_ready,
    output wr_ready, rd_valid, rd_data, rd_src, irq
  );

endinterface

`default_nettype wire

//--- hw/flit_if.sv
`timescale 1ns/1ns
`default_nettype none

interface flit_if;

  // Flit leaving the tile
  logic            tx_valid;
  noc_pkg::flit_t  tx_flit;
  logic            tx_ready;

  // Flit delivered into the tile
  logic            rx_valid;
  noc_pkg::flit_t  rx_flit;
  logic            rx_ready;

  modport node (
    output tx_valid, tx_flit, rx_ready,
    input  tx_ready, rx_valid, rx_flit
  );

  modport xbar (
    input  tx_valid, tx_flit, rx_ready,
    output tx_ready, rx_valid, rx_flit
  );

endinterface

`default_nettype wire

//--- hw/ni_node.sv
`timescale 1ns/1ns
`default_nettype none

module ni_node (
  input  logic               clk_axi,
  input  logic               rst_n,
  ni_port_if.node            host,
  flit_if.node               net,
  input  noc_pkg::node_id_t  node_id
);

  logic                          init_done;
  logic                          tx_valid_q;
  noc_pkg::flit_t                tx_flit_q;
  logic                          wr_push;

  noc_pkg::flit_t                rx_mem [noc_pkg::RX_DEPTH];
  logic [noc_pkg::RX_PTR_W-1:0]  rx_wr_ptr;
  logic [noc_pkg::RX_PTR_W-1:0]  rx_rd_ptr;
  logic [noc_pkg::RX_CNT_W-1:0]  rx_count;
  logic                          rx_push;
  logic                          rx_pop;

  // One flit in flight per tile and nothing accepted during reset
  assign host.wr_ready = init_done && !tx_valid_q;
  assign wr_push       = host.wr_valid && host.wr_ready;

  assign net.tx_valid  = tx_valid_q;
  assign net.tx_flit   = tx_flit_q;

  always_ff @(posedge clk_axi) begin
    if (!rst_n) begin
      init_done  <= 1'b0;
      tx_valid_q <= 1'b0;
    end else begin
      init_done <= 1'b1;
      if (wr_push) begin
        tx_valid_q <= 1'b1;
      end else if (tx_valid_q && net.tx_ready) begin
        tx_valid_q <= 1'b0;
      end
    end
  end

  // Source id is stamped here as the host gives only dest and data
  always_ff @(posedge clk_axi) begin
    if (wr_push) begin
      tx_flit_q.src  <= node_id;
      tx_flit_q.dest <= host.wr_dest;
      tx_flit_q.data <= host.wr_data;
    end
  end

  // Receive queue with its oldest entry shown at the head
  assign net.rx_ready  = (rx_count != noc_pkg::RX_CNT_W'(noc_pkg::RX_DEPTH));
  assign rx_push       = net.rx_valid && net.rx_ready;
  assign host.rd_valid = (rx_count != '0);
  assign rx_pop        = host.rd_valid && host.rd_ready;
  assign host.rd_data  = rx_mem[rx_rd_ptr].data;
  assign host.rd_src   = rx_mem[rx_rd_ptr].src;
  assign host.irq      = (rx_count != '0);

  always_ff @(posedge clk_axi) begin
    if (rx_push) begin
      rx_mem[rx_wr_ptr] <= net.rx_flit;
    end
  end

  always_ff @(posedge clk_axi) begin
    if (!rst_n) begin
      rx_wr_ptr <= '0;
      rx_rd_ptr <= '0;
      rx_count  <= '0;
    end else begin
      if (rx_push) begin
        if (rx_wr_ptr == noc_pkg::RX_PTR_W'(noc_pkg::RX_DEPTH - 1))
          rx_wr_ptr <= '0;
        else
          rx_wr_ptr <= rx_wr_ptr + 1'b1;
      end
      if (rx_pop) begin
        if (rx_rd_ptr == noc_pkg::RX_PTR_W'(noc_pkg::RX_DEPTH - 1))
          rx_rd_ptr <= '0;
        else
          rx_rd_ptr <= rx_rd_ptr + 1'b1;
      end
      // Count moves only when exactly one side is active
      if (rx_push && !rx_pop)
        rx_count <= rx_count + 1'b1;
      else if (rx_pop && !rx_push)
        rx_count <= rx_count - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/noc_xbar.sv
`timescale 1ns/1ns
`default_nettype none

module noc_xbar (
  input  logic  clk_axi,
  input  logic  rst_n,
  flit_if.xbar  nodes [noc_pkg::NOC_SIZE]
);

  logic [noc_pkg::NOC_SIZE-1:0]  tx_valid;
  noc_pkg::flit_t                tx_flit  [noc_pkg::NOC_SIZE];
  logic [noc_pkg::NOC_SIZE-1:0]  rx_ready;

  noc_pkg::node_id_t             rr_ptr   [noc_pkg::NOC_SIZE];
  noc_pkg::node_id_t             winner   [noc_pkg::NOC_SIZE];
  logic [noc_pkg::NOC_SIZE-1:0]  found;
  logic [noc_pkg::NOC_SIZE-1:0]  tx_grant;

  // Interface signals gathered into arrays for the arbiter
  for (genvar g = 0; g < noc_pkg::NOC_SIZE; g++) begin : g_port
    assign tx_valid[g]       = nodes[g].tx_valid;
    assign tx_flit[g]        = nodes[g].tx_flit;
    assign rx_ready[g]       = nodes[g].rx_ready;
    assign nodes[g].tx_ready = tx_grant[g];
    assign nodes[g].rx_valid = found[g];
    assign nodes[g].rx_flit  = tx_flit[winner[g]];
  end

  // First requester at or after the pointer wins each destination
  always_comb begin
    int cand;
    for (int d = 0; d < noc_pkg::NOC_SIZE; d++) begin
      found[d]  = 1'b0;
      winner[d] = '0;
      for (int k = 0; k < noc_pkg::NOC_SIZE; k++) begin
        cand = (int'(rr_ptr[d]) + k) % noc_pkg::NOC_SIZE;
        if (!found[d] && tx_valid[cand] &&
            tx_flit[cand].dest == noc_pkg::node_id_t'(d)) begin
          found[d]  = 1'b1;
          winner[d] = noc_pkg::node_id_t'(cand);
        end
      end
    end
    for (int s = 0; s < noc_pkg::NOC_SIZE; s++) begin
      tx_grant[s] = 1'b0;
      for (int d = 0; d < noc_pkg::NOC_SIZE; d++) begin
        if (found[d] && rx_ready[d] && winner[d] == noc_pkg::node_id_t'(s))
          tx_grant[s] = 1'b1;
      end
    end
  end

  // Pointer moves past the winner only on an accepted transfer
  always_ff @(posedge clk_axi) begin
    if (!rst_n) begin
      for (int d = 0; d < noc_pkg::NOC_SIZE; d++)
        rr_ptr[d] <= '0;
    end else begin
      for (int d = 0; d < noc_pkg::NOC_SIZE; d++) begin
        if (found[d] && rx_ready[d])
          rr_ptr[d] <= noc_pkg::node_id_t'((int'(winner[d]) + 1) % noc_pkg::NOC_SIZE);
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/noc_port_mux.sv
`timescale 1ns/1ns
`default_nettype none

module noc_port_mux (
  input  noc_pkg::node_id_t              axi_sel,
  input  logic                           wr_valid,
  input  noc_pkg::node_id_t              wr_dest,
  input  logic [noc_pkg::DATA_W-1:0]     wr_data,
  output logic                           wr_ready,
  output logic                           rd_valid,
  output logic [noc_pkg::DATA_W-1:0]     rd_data,
  output noc_pkg::node_id_t              rd_src,
  input  logic                           rd_ready,
  output logic [noc_pkg::NOC_SIZE-1:0]   irqs_out,
  ni_port_if.mux                         ports [noc_pkg::NOC_SIZE]
);

  logic [noc_pkg::NOC_SIZE-1:0]  tile_wr_ready;
  logic [noc_pkg::NOC_SIZE-1:0]  tile_rd_valid;
  logic [noc_pkg::DATA_W-1:0]    tile_rd_data [noc_pkg::NOC_SIZE];
  noc_pkg::node_id_t             tile_rd_src  [noc_pkg::NOC_SIZE];

  for (genvar g = 0; g < noc_pkg::NOC_SIZE; g++) begin : g_tile
    // Handshake strobes reach the selected tile only
    assign ports[g].wr_valid = wr_valid && (axi_sel == noc_pkg::node_id_t'(g));
    assign ports[g].rd_ready = rd_ready && (axi_sel == noc_pkg::node_id_t'(g));
    assign ports[g].wr_dest  = wr_dest;
    assign ports[g].wr_data  = wr_data;

    assign tile_wr_ready[g]  = ports[g].wr_ready;
    assign tile_rd_valid[g]  = ports[g].rd_valid;
    assign tile_rd_data[g]   = ports[g].rd_data;
    assign tile_rd_src[g]    = ports[g].rd_src;
    assign irqs_out[g]       = ports[g].irq;
  end

  always_comb begin
    wr_ready = 1'b0;
    rd_valid = 1'b0;
    rd_data  = '0;
    rd_src   = '0;
    for (int i = 0; i < noc_pkg::NOC_SIZE; i++) begin
      if (axi_sel == noc_pkg::node_id_t'(i)) begin
        wr_ready = tile_wr_ready[i];
        rd_valid = tile_rd_valid[i];
        rd_data  = tile_rd_data[i];
        rd_src   = tile_rd_src[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/noc_top.sv
`timescale 1ns/1ns
`default_nettype none

module noc_top (
  input  logic                           clk_axi,
  input  logic                           rst_n,
  input  noc_pkg::node_id_t              axi_sel,
  input  logic                           wr_valid,
  input  noc_pkg::node_id_t              wr_dest,
  input  logic [noc_pkg::DATA_W-1:0]     wr_data,
  input  logic                           rd_ready,
  output logic                           wr_ready,
  output logic                           rd_valid,
  output logic [noc_pkg::DATA_W-1:0]     rd_data,
  output noc_pkg::node_id_t              rd_src,
  output logic [noc_pkg::NOC_SIZE-1:0]   irqs_out
);

  ni_port_if port_if [noc_pkg::NOC_SIZE] ();
  flit_if    net_if  [noc_pkg::NOC_SIZE] ();

  noc_port_mux u_port_mux (
    .axi_sel  (axi_sel),
    .wr_valid (wr_valid),
    .wr_dest  (wr_dest),
    .wr_data  (wr_data),
    .wr_ready (wr_ready),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .rd_src   (rd_src),
    .rd_ready (rd_ready),
    .irqs_out (irqs_out),
    .ports    (port_if)
  );

  // Tile id comes from its position in the array
  for (genvar g = 0; g < noc_pkg::NOC_SIZE; g++) begin : g_node
    ni_node u_node (
      .clk_axi (clk_axi),
      .rst_n   (rst_n),
      .host    (port_if[g]),
      .net     (net_if[g]),
      .node_id (noc_pkg::node_id_t'(g))
    );
  end

  noc_xbar u_xbar (
    .clk_axi (clk_axi),
    .rst_n   (rst_n),
    .nodes   (net_if)
  );

endmodule

`default_nettype wire

//--- bench/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic clk_axi,
  output logic rst_n
);

  localparam int HALF_PERIOD = 4;

  initial begin
    clk_axi = 1'b0;
    forever #HALF_PERIOD clk_axi = ~clk_axi;
  end

  // Reset held over two rising edges
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk_axi);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/noc_checker.sv
`timescale 1ns/1ns
`default_nettype none

module noc_checker (
  input logic                          clk_axi,
  input logic                          rst_n,
  input noc_pkg::node_id_t             axi_sel,
  input logic                          rd_valid,
  input logic                          rd_ready,
  input logic [noc_pkg::DATA_W-1:0]    rd_data,
  input noc_pkg::node_id_t             rd_src,
  input logic                          wr_ready,
  input logic [noc_pkg::NOC_SIZE-1:0]  irqs_out
);

  int fail_count = 0;

  // Queue head holds while the host stalls on the same tile
  a_rd_hold: assert property (@(posedge clk_axi) disable iff (!rst_n)
    rd_valid && !rd_ready |=> (axi_sel != $past(axi_sel)) ||
      (rd_valid && $stable(rd_data) && $stable(rd_src)))
    else begin
      fail_count++;
      $error("read data changed before the host accepted it");
    end

  a_irq_after_reset: assert property (@(posedge clk_axi)
    $rose(rst_n) |-> irqs_out == '0)
    else begin
      fail_count++;
      $error("interrupts raised right after reset");
    end

  a_no_ready_in_reset: assert property (@(posedge clk_axi)
    !rst_n |-> wr_ready !== 1'b1)
    else begin
      fail_count++;
      $error("write ready high during reset");
    end

endmodule

bind noc_top noc_checker u_checker (.*);

`default_nettype wire

//--- bench/noc_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module noc_monitor (
  input logic                        clk_axi,
  input logic                        rst_n,
  input noc_pkg::node_id_t           axi_sel,
  input logic                        rd_valid,
  input logic                        rd_ready,
  input logic [noc_pkg::DATA_W-1:0]  rd_data,
  input noc_pkg::node_id_t           rd_src,
  input logic                        exp_known,
  input logic [noc_pkg::DATA_W-1:0]  exp_data
);

  string test_name   = "none";
  int    err_count   = 0;
  int    check_count = 0;
  int    read_count  = 0;

  task automatic start_test(input string name);
    test_name = name;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Fail %s %s expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  // Every read handshake against the model head of its pair
  always @(posedge clk_axi) begin
    if (rst_n && rd_valid && rd_ready) begin
      read_count++;
      check_count++;
      if (!exp_known) begin
        err_count++;
        $display("Error in %s: tile %0d returned a message from tile %0d that was never sent",
                 test_name, axi_sel, rd_src);
      end else if (rd_data !== exp_data) begin
        err_count++;
        $display("Fail %s rd_data expected %h actual %h", test_name, exp_data, rd_data);
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/noc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module noc_tb;

  localparam int          TIMEOUT     = 200;
  localparam int          MODEL_DEPTH = 256;
  localparam int          PAIRS       = noc_pkg::NOC_SIZE * noc_pkg::NOC_SIZE;
  localparam int unsigned LCG_MUL     = 32'd1664525;
  localparam int unsigned LCG_INC     = 32'd1013904223;

  logic                          clk_axi;
  logic                          rst_n;
  noc_pkg::node_id_t             axi_sel;
  noc_pkg::node_id_t             wr_dest;
  noc_pkg::node_id_t             rd_src;
  logic                          wr_valid;
  logic                          wr_ready;
  logic                          rd_valid;
  logic                          rd_ready;
  logic [noc_pkg::DATA_W-1:0]    wr_data;
  logic [noc_pkg::DATA_W-1:0]    rd_data;
  logic [noc_pkg::NOC_SIZE-1:0]  irqs_out;
  logic                          exp_known;
  logic [noc_pkg::DATA_W-1:0]    exp_data;
  int unsigned                   lcg_state;
  int                            timeouts;

  // Reference model with one FIFO per source and destination pair
  logic [noc_pkg::DATA_W-1:0]    model_mem [PAIRS*MODEL_DEPTH];
  int                            model_wr  [PAIRS];
  int                            model_rd  [PAIRS];

  tb_clkgen u_clkgen (.clk_axi (clk_axi), .rst_n (rst_n));

  noc_top dut (
    .clk_axi  (clk_axi),  .rst_n    (rst_n),    .axi_sel  (axi_sel),
    .wr_valid (wr_valid), .wr_dest  (wr_dest),  .wr_data  (wr_data),
    .rd_ready (rd_ready), .wr_ready (wr_ready), .rd_valid (rd_valid),
    .rd_data  (rd_data),  .rd_src   (rd_src),   .irqs_out (irqs_out)
  );

  noc_monitor u_mon (
    .clk_axi  (clk_axi),  .rst_n    (rst_n),    .axi_sel   (axi_sel),
    .rd_valid (rd_valid), .rd_ready (rd_ready), .rd_data   (rd_data),
    .rd_src   (rd_src),   .exp_known (exp_known), .exp_data (exp_data)
  );

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * LCG_MUL + LCG_INC;
    return lcg_state;
  endfunction

  function automatic int pair_index(input int src, input int dest);
    return src * noc_pkg::NOC_SIZE + dest;
  endfunction

  function automatic int model_count(input int src, input int dest);
    return model_wr[pair_index(src, dest)] - model_rd[pair_index(src, dest)];
  endfunction

  // Oldest outstanding payload from src to dest
  function automatic logic [31:0] ref_expected(input int src, input int dest);
    int p;
    p = pair_index(src, dest);
    return model_mem[p*MODEL_DEPTH + model_rd[p] % MODEL_DEPTH];
  endfunction

  function automatic int outstanding();
    int total;
    total = 0;
    for (int p = 0; p < PAIRS; p++)
      total += model_wr[p] - model_rd[p];
    return total;
  endfunction

  // First set interrupt bit at or after start
  function automatic int pick_irq(input logic [noc_pkg::NOC_SIZE-1:0] bits, input int start);
    int t;
    t = -1;
    for (int k = noc_pkg::NOC_SIZE - 1; k >= 0; k--) begin
      if (bits[(start + k) % noc_pkg::NOC_SIZE])
        t = (start + k) % noc_pkg::NOC_SIZE;
    end
    return t;
  endfunction

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
  endtask

  task automatic do_write(input int src, input int dest, input logic [31:0] data);
    int n;
    int p;
    axi_sel  = noc_pkg::node_id_t'(src);
    wr_dest  = noc_pkg::node_id_t'(dest);
    wr_data  = data;
    wr_valid = 1'b1;
    n = 0;
    @(negedge clk_axi);
    while (!wr_ready && n < TIMEOUT) begin
      @(negedge clk_axi);
      n++;
    end
    if (wr_ready) begin
      p = pair_index(src, dest);
      model_mem[p*MODEL_DEPTH + model_wr[p] % MODEL_DEPTH] = data;
      model_wr[p]++;
    end else begin
      report_timeout("write handshake");
    end
    @(posedge clk_axi);
    #1;
    wr_valid = 1'b0;
  endtask

  // A negative exp_src accepts any source
  task automatic do_read(input int tile, input int exp_src);
    int n;
    int src;
    axi_sel = noc_pkg::node_id_t'(tile);
    n = 0;
    @(negedge clk_axi);
    while (!rd_valid && n < TIMEOUT) begin
      @(negedge clk_axi);
      n++;
    end
    if (!rd_valid) begin
      report_timeout("read data valid");
      @(posedge clk_axi);
      #1;
    end else begin
      src = int'(rd_src);
      if (exp_src >= 0)
        u_mon.check_value("rd_src", exp_src, src);
      exp_known = (model_count(src, tile) > 0);
      exp_data  = ref_expected(src, tile);
      @(posedge clk_axi);
      #1;
      rd_ready = 1'b1;
      @(posedge clk_axi);
      #1;
      rd_ready = 1'b0;
      if (exp_known)
        model_rd[pair_index(src, tile)]++;
    end
  endtask

  task automatic wait_irq(input int tile);
    int n;
    n = 0;
    @(negedge clk_axi);
    while (!irqs_out[tile] && n < TIMEOUT) begin
      @(negedge clk_axi);
      n++;
    end
    if (!irqs_out[tile])
      report_timeout("receive interrupt");
    @(posedge clk_axi);
    #1;
  endtask

  // Waits for a free transmit register and reads queues meanwhile if drain is set
  task automatic make_room(input int src, input bit drain);
    int n;
    axi_sel = noc_pkg::node_id_t'(src);
    n = 0;
    @(negedge clk_axi);
    while (!wr_ready && n < TIMEOUT) begin
      @(posedge clk_axi);
      #1;
      if (drain && irqs_out != '0)
        do_read(pick_irq(irqs_out, 0), -1);
      axi_sel = noc_pkg::node_id_t'(src);
      @(negedge clk_axi);
      n++;
    end
    if (!wr_ready)
      report_timeout("transmit register free");
    @(posedge clk_axi);
    #1;
  endtask

  initial begin
    int          n;
    int unsigned r;
    logic        stuck;
    axi_sel   = '0;
    wr_valid  = 1'b0;
    wr_dest   = '0;
    wr_data   = '0;
    rd_ready  = 1'b0;
    exp_known = 1'b0;
    exp_data  = '0;
    lcg_state = 76;
    timeouts  = 0;
    for (int p = 0; p < PAIRS; p++) begin
      model_wr[p] = 0;
      model_rd[p] = 0;
    end
    n = 0;
    while (!rst_n && n < TIMEOUT) begin
      @(posedge clk_axi);
      n++;
    end
    if (!rst_n)
      report_timeout("reset release");
    @(posedge clk_axi);
    #1;

    u_mon.start_test("reset");
    for (int s = 0; s < noc_pkg::NOC_SIZE; s++) begin
      axi_sel = noc_pkg::node_id_t'(s);
      @(negedge clk_axi);
      u_mon.check_value("rd_valid", 0, rd_valid);
      u_mon.check_value("wr_ready", 1, wr_ready);
      u_mon.check_value("irqs_out", 0, irqs_out);
      @(posedge clk_axi);
      #1;
    end

    u_mon.start_test("unicast");
    do_write(0, 2, lcg_next());
    wait_irq(2);
    u_mon.check_value("irqs_out", 4'b0100, irqs_out);
    do_read(2, 0);
    @(negedge clk_axi);
    u_mon.check_value("irqs_out after read", 0, irqs_out);
    @(posedge clk_axi);
    #1;

    u_mon.start_test("loopback");
    do_write(1, 1, lcg_next());
    wait_irq(1);
    do_read(1, 1);

    // Four flits fill tile 0 and the fifth parks in the tile 3 transmit register
    u_mon.start_test("backpressure");
    for (int i = 0; i < 5; i++)
      do_write(3, 0, lcg_next());
    stuck = 1'b0;
    for (int k = 0; k < 8; k++) begin
      @(negedge clk_axi);
      stuck = stuck | wr_ready;
    end
    u_mon.check_value("wr_ready after fifth write", 0, stuck);
    u_mon.check_value("irqs_out", 4'b0001, irqs_out);
    @(posedge clk_axi);
    #1;
    do_read(0, 3);
    make_room(3, 1'b0);
    for (int i = 0; i < 4; i++)
      do_read(0, 3);

    u_mon.start_test("random");
    for (int i = 0; i < 200; i++) begin
      r = lcg_next();
      make_room(int'(r[31:30]), 1'b1);
      do_write(int'(r[31:30]), int'(r[29:28]), lcg_next());
      if (r[27:26] == 2'd0 && irqs_out != '0)
        do_read(pick_irq(irqs_out, int'(r[25:24])), -1);
    end
    n = 0;
    while (outstanding() > 0 && n < TIMEOUT) begin
      if (irqs_out != '0)
        do_read(pick_irq(irqs_out, 0), -1);
      else begin
        @(posedge clk_axi);
        #1;
      end
      n++;
    end
    if (outstanding() > 0)
      report_timeout("draining of all queues");
    @(negedge clk_axi);
    u_mon.check_value("model messages left", 0, outstanding());
    u_mon.check_value("irqs_out after drain", 0, irqs_out);
    @(posedge clk_axi);

    $display("Summary: %0d checks, %0d reads, %0d errors, %0d timeouts, %0d assertion failures",
             u_mon.check_count, u_mon.read_count, u_mon.err_count, timeouts,
             dut.u_checker.fail_count);
    if (u_mon.err_count == 0 && timeouts == 0 && dut.u_checker.fail_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
hw/noc_pkg.sv
hw/ni_port_if.sv
hw/flit_if.sv
hw/ni_node.sv
hw/noc_xbar.sv
hw/noc_port_mux.sv
hw/noc_top.sv
bench/tb_clkgen.sv
bench/noc_checker.sv
bench/noc_monitor.sv
bench/noc_tb.sv
